// ==== wg_stim.txt ====
# op hart addr wdata exp_rdata exp_error cmp, all numbers hex; halt/resume exp_rdata is o_halted
# cmp 0 none, 1 equal, 2 capture, 3 equal to captured, 4 above captured; irq wdata is seip:meip:mtip:msip
write 0 00 12345678 00000000 1 1
read 0 00 0 00000000 0 1
halt 2 0 0 4 0 1
write 2 00 deadbeef 0 0 1
write 2 07 a5a55a5a 0 0 1
read 2 00 0 deadbeef 0 1
read 2 07 0 a5a55a5a 0 1
read 1 00 0 0 0 1
read 3 07 0 0 0 1
halt 1 0 0 6 0 1
read 1 40 0 0 0 2
read 1 40 0 0 0 3
resume 1 0 0 4 0 1
read 1 40 0 0 0 4
irq 0 0 6835 0 0 0
read 0 41 0 3 0 1
read 1 41 0 a 0 1
read 2 41 0 9 0 1
read 3 41 0 4 0 1
write 0 40 ffffffff 0 1 1
read 0 45 0 0 1 1
read 0 c0 0 0 1 1
write 3 c1 1 0 1 1
resume 2 0 0 0 0 1
read 2 00 0 deadbeef 0 1
write 2 01 5 0 1 1

// ==== src.f ====
+incdir+.
wg_pkg.sv
dport_if.sv
dport_ic.sv
hart_dbg.sv
workgroup.sv
tb_clkgen.sv
tb_workgroup.sv

// ==== tb_workgroup.sv ====
// Testbench for the workgroup top that replays wg_stim.txt through the debug port and checks responses
`timescale 1ns/1ps
`include "wg_consts.svh"

module tb_workgroup;

    localparam int RESET_CYCLES = 10;

    logic                        clk;
    logic                        rst_n;
    logic                        i_req_valid;
    logic                        o_req_ready;
    logic [`WG_HART_IDX_W-1:0]   i_req_hartsel;
    wg_pkg::dport_req_e          i_req_type;
    logic [`WG_ADDR_W-1:0]       i_req_addr;
    logic [`WG_DATA_W-1:0]       i_req_wdata;
    logic                        o_resp_valid;
    logic                        i_resp_ready;
    logic [`WG_DATA_W-1:0]       o_resp_rdata;
    logic                        o_resp_error;
    logic                        i_haltreq;
    logic                        i_resumereq;
    logic [`WG_HART_NUM-1:0]     i_msip, i_mtip, i_meip, i_seip;
    logic [`WG_HART_NUM-1:0]     o_halted;
    logic [`WG_HART_NUM-1:0]     o_available;

    // Stimulus table with one entry per operation line
    string         op_q[$];
    int            line_q[$];
    logic [31:0]   hart_q[$], addr_q[$], wdata_q[$], exp_q[$], err_q[$], cmp_q[$];

    int            errors;
    int            checks;
    int            cycles;
    int            cycle_limit;
    integer        seed;
    bit            timed_out;
    logic [31:0]   captured;                   // Value kept for later comparisons

    tb_clkgen u_clkgen (.o_clk(clk));

    workgroup DUT (
        .i_clk (clk), .i_rst_n (rst_n),
        .i_req_valid (i_req_valid), .o_req_ready (o_req_ready),
        .i_req_hartsel (i_req_hartsel), .i_req_type (i_req_type),
        .i_req_addr (i_req_addr), .i_req_wdata (i_req_wdata),
        .o_resp_valid (o_resp_valid), .i_resp_ready (i_resp_ready),
        .o_resp_rdata (o_resp_rdata), .o_resp_error (o_resp_error),
        .i_haltreq (i_haltreq), .i_resumereq (i_resumereq),
        .i_msip (i_msip), .i_mtip (i_mtip), .i_meip (i_meip), .i_seip (i_seip),
        .o_halted (o_halted), .o_available (o_available)
    );

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("[ERROR] %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic finish_run();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    endtask

    task automatic load_stim();
        int          fd;
        int          lineno;
        int          n;
        string       line;
        string       op;
        logic [31:0] h, a, w, e, r, c;
        fd = $fopen("wg_stim.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the stimulus file wg_stim.txt");
            errors++;
            return;
        end
        lineno = 0;
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            lineno++;
            if (n == 0 || line.len() < 2 || line[0] == "#") continue;   // Blank or comment
            if ($sscanf(line, "%s %h %h %h %h %h %h", op, h, a, w, e, r, c) != 7) begin
                $display("Malformed stimulus on line %0d of wg_stim.txt", lineno);
                errors++;
                continue;
            end
            op_q.push_back(op);
            line_q.push_back(lineno);
            hart_q.push_back(h);
            addr_q.push_back(a);
            wdata_q.push_back(w);
            exp_q.push_back(e);
            err_q.push_back(r);
            cmp_q.push_back(c);
        end
        $fclose(fd);
    endtask

    // One debug-port transfer entered on a falling edge with a random response delay
    task automatic do_access(input int k);
        string       name;
        int          delay;
        logic [31:0] rdata;
        logic        err;
        name = $sformatf("line %0d %s hart %0d", line_q[k], op_q[k], hart_q[k]);
        while (!o_req_ready) @(negedge clk);
        i_req_valid   = 1'b1;
        i_req_hartsel = `WG_HART_IDX_W'(hart_q[k]);
        i_req_type    = (op_q[k] == "write") ? wg_pkg::DPORT_WRITE : wg_pkg::DPORT_READ;
        i_req_addr    = `WG_ADDR_W'(addr_q[k]);
        i_req_wdata   = wdata_q[k];
        @(negedge clk);
        i_req_valid = 1'b0;
        while (!o_resp_valid) begin
            check({name, " req_ready while busy"}, 0, o_req_ready);
            @(negedge clk);
        end
        check({name, " req_ready while busy"}, 0, o_req_ready);
        rdata = o_resp_rdata;
        err   = o_resp_error;
        delay = $unsigned($random(seed)) % 4;
        repeat (delay) begin                   // Back-pressure, response must not move
            @(negedge clk);
            check({name, " resp_valid held"}, 1, o_resp_valid);
            check({name, " resp_rdata held"}, rdata, o_resp_rdata);
            check({name, " resp_error held"}, err, o_resp_error);
            check({name, " req_ready while held"}, 0, o_req_ready);
        end
        i_resp_ready = 1'b1;
        @(negedge clk);
        i_resp_ready = 1'b0;
        check({name, " resp_valid after transfer"}, 0, o_resp_valid);
        check({name, " req_ready after transfer"}, 1, o_req_ready);
        check({name, " error"}, err_q[k], err);
        case (cmp_q[k])
            1: check({name, " rdata"}, exp_q[k], rdata);
            2: captured = rdata;
            3: check({name, " same as captured"}, captured, rdata);
            4: check({name, " above captured"}, 1, rdata > captured);
            default: ;
        endcase
    endtask

    // Halt, resume and irq are level pulses applied between transfers
    task automatic run_control(input int k);
        string name;
        name = $sformatf("line %0d %s hart %0d halted", line_q[k], op_q[k], hart_q[k]);
        i_req_hartsel = `WG_HART_IDX_W'(hart_q[k]);
        if (op_q[k] == "irq") begin
            i_msip = wdata_q[k][3:0];
            i_mtip = wdata_q[k][7:4];
            i_meip = wdata_q[k][11:8];
            i_seip = wdata_q[k][15:12];
            repeat (2) @(negedge clk);
        end else begin
            i_haltreq   = (op_q[k] == "halt");
            i_resumereq = (op_q[k] == "resume");
            @(negedge clk);
            i_haltreq   = 1'b0;
            i_resumereq = 1'b0;
            if (cmp_q[k] != 0) check(name, exp_q[k], o_halted);
        end
    endtask

    initial begin
        seed = 92411;
        rst_n = 1'b0;
        i_req_valid = 1'b0;
        i_req_hartsel = '0;
        i_req_type = wg_pkg::DPORT_READ;
        i_req_addr = '0;
        i_req_wdata = '0;
        i_resp_ready = 1'b0;
        i_haltreq = 1'b0;
        i_resumereq = 1'b0;
        {i_msip, i_mtip, i_meip, i_seip} = '0;
        errors = 0;
        checks = 0;
        cycle_limit = 0;
        timed_out = 1'b0;
        captured = '0;
        load_stim();
        if (errors != 0) begin
            finish_run();
        end else begin
            cycle_limit = 40 * op_q.size() + 100;
            repeat (RESET_CYCLES) @(negedge clk);
            rst_n = 1'b1;
            @(negedge clk);
            check("reset halted", 0, o_halted);
            check("reset available", {`WG_HART_NUM{1'b1}}, o_available);
            check("reset req_ready", 1, o_req_ready);
            check("reset resp_valid", 0, o_resp_valid);
            foreach (op_q[k]) begin
                if (op_q[k] == "read" || op_q[k] == "write") do_access(k);
                else run_control(k);
            end
            repeat (2) @(negedge clk);
            finish_run();
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycle_limit != 0 && cycles >= cycle_limit) begin
            $display("Timeout, the run did not finish within %0d cycles", cycle_limit);
            timed_out = 1'b1;
            finish_run();
        end
    end

endmodule

// ==== tb_clkgen.sv ====
// Free-running testbench clock, 8 ns period, starts low at time zero
`timescale 1ns/1ps

module tb_clkgen #(
    parameter real HALF_PERIOD_NS = 4.0    // Half of the 8 ns period
) (
    output logic o_clk
);

    initial begin
        o_clk = 1'b0;
    end

    always begin
        #(HALF_PERIOD_NS) o_clk = ~o_clk;
    end

endmodule

// ==== workgroup.sv ====
// Workgroup top level, one debug-port interconnect feeding a hart debug unit per slot
`timescale 1ns/1ps
`include "wg_consts.svh"

module workgroup (
    input  logic                         i_clk,
    input  logic                         i_rst_n,
    input  logic                         i_req_valid,
    output logic                         o_req_ready,
    input  logic [`WG_HART_IDX_W-1:0]    i_req_hartsel,
    input  wg_pkg::dport_req_e           i_req_type,
    input  logic [`WG_ADDR_W-1:0]        i_req_addr,
    input  logic [`WG_DATA_W-1:0]        i_req_wdata,
    output logic                         o_resp_valid,
    input  logic                         i_resp_ready,
    output logic [`WG_DATA_W-1:0]        o_resp_rdata,
    output logic                         o_resp_error,
    input  logic                         i_haltreq,
    input  logic                         i_resumereq,
    input  logic [`WG_HART_NUM-1:0]      i_msip,
    input  logic [`WG_HART_NUM-1:0]      i_mtip,
    input  logic [`WG_HART_NUM-1:0]      i_meip,
    input  logic [`WG_HART_NUM-1:0]      i_seip,
    output logic [`WG_HART_NUM-1:0]      o_halted,
    output logic [`WG_HART_NUM-1:0]      o_available
);

    logic [`WG_HART_NUM-1:0]            hart_haltreq;
    logic [`WG_HART_NUM-1:0]            hart_resumereq;
    logic [`WG_HART_NUM-1:0]            hart_halted;
    logic [wg_pkg::IRQ_TOTAL-1:0]       hart_irq [`WG_HART_NUM];

    dport_if dport [`WG_HART_NUM] ();              // One channel per hart

    dport_ic u_dport_ic (
        .i_clk            (i_clk),
        .i_rst_n          (i_rst_n),
        .i_req_valid      (i_req_valid),
        .o_req_ready      (o_req_ready),
        .i_req_hartsel    (i_req_hartsel),
        .i_req_type       (i_req_type),
        .i_req_addr       (i_req_addr),
        .i_req_wdata      (i_req_wdata),
        .o_resp_valid     (o_resp_valid),
        .i_resp_ready     (i_resp_ready),
        .o_resp_rdata     (o_resp_rdata),
        .o_resp_error     (o_resp_error),
        .i_haltreq        (i_haltreq),
        .i_resumereq      (i_resumereq),
        .o_hart_haltreq   (hart_haltreq),
        .o_hart_resumereq (hart_resumereq),
        .i_hart_halted    (hart_halted),
        .o_halted         (o_halted),
        .o_available      (o_available),
        .harts            (dport)
    );

    for (genvar g = 0; g < `WG_HART_NUM; g++) begin : g_hart
        // Per-hart pending word from the four interrupt vectors
        assign hart_irq[g][wg_pkg::IRQ_MSIP] = i_msip[g];
        assign hart_irq[g][wg_pkg::IRQ_MTIP] = i_mtip[g];
        assign hart_irq[g][wg_pkg::IRQ_MEIP] = i_meip[g];
        assign hart_irq[g][wg_pkg::IRQ_SEIP] = i_seip[g];

        hart_dbg u_hart (
            .i_clk       (i_clk),
            .i_rst_n     (i_rst_n),
            .i_haltreq   (hart_haltreq[g]),
            .i_resumereq (hart_resumereq[g]),
            .i_irq       (hart_irq[g]),
            .o_halted    (hart_halted[g]),
            .dport       (dport[g])
        );
    end

endmodule

// ==== hart_dbg.sv ====
// Debug-side hart model with run/halt state, cycle counter, GPRs and interrupt-pending word
`timescale 1ns/1ps
`include "wg_consts.svh"

module hart_dbg (
    input  logic                              i_clk,
    input  logic                              i_rst_n,
    input  logic                              i_haltreq,
    input  logic                              i_resumereq,
    input  logic [wg_pkg::IRQ_TOTAL-1:0]      i_irq,
    output logic                              o_halted,
    dport_if.hart                             dport
);

    localparam int unsigned GPR_IDX_W = $clog2(`WG_GPR_NUM);
    localparam logic [wg_pkg::IDX_W-1:0] GPR_LIMIT = wg_pkg::IDX_W'(`WG_GPR_NUM);

    logic                              halted_q;
    logic [`WG_DATA_W-1:0]             cycle_q;
    logic [wg_pkg::IRQ_TOTAL-1:0]      irq_pending_q;
    logic [`WG_DATA_W-1:0]             gpr_q [`WG_GPR_NUM];

    logic                              resp_valid_q;
    logic [`WG_DATA_W-1:0]             resp_rdata_q;
    logic                              resp_error_q;

    // Request decode
    wg_pkg::reg_region_e               region;
    logic [wg_pkg::IDX_W-1:0]          idx;
    logic [GPR_IDX_W-1:0]              gpr_idx;
    logic                              is_read;
    logic                              is_write;
    logic                              req_fire;
    logic                              gpr_we;
    logic [`WG_DATA_W-1:0]             rdata_d;
    logic                              error_d;

    assign dport.req_ready = !resp_valid_q;        // One response outstanding at most
    assign req_fire        = dport.req_valid && dport.req_ready;

    assign region   = wg_pkg::reg_region_e'(dport.req_addr[`WG_ADDR_W-1 -: 2]);
    assign idx      = dport.req_addr[wg_pkg::IDX_W-1:0];
    assign gpr_idx  = idx[GPR_IDX_W-1:0];
    assign is_read  = (dport.req_type == wg_pkg::DPORT_READ);
    assign is_write = (dport.req_type == wg_pkg::DPORT_WRITE);

    always_comb begin
        rdata_d = '0;
        error_d = 1'b1;                            // Anything not matched below is refused
        gpr_we  = 1'b0;
        case (region)
            wg_pkg::REGION_GPR: begin
                if (idx < GPR_LIMIT) begin
                    if (is_read) begin
                        rdata_d = gpr_q[gpr_idx];
                        error_d = 1'b0;
                    end else if (is_write && halted_q) begin
                        gpr_we  = req_fire;        // GPRs only change while halted
                        error_d = 1'b0;
                    end
                end
            end
            wg_pkg::REGION_CSR: begin
                if (is_read) begin
                    if (idx == wg_pkg::CSR_CYCLE) begin
                        rdata_d = cycle_q;
                        error_d = 1'b0;
                    end else if (idx == wg_pkg::CSR_IRQ_PENDING) begin
                        rdata_d = `WG_DATA_W'(irq_pending_q);
                        error_d = 1'b0;
                    end
                end
            end
            default: begin
                error_d = 1'b1;                    // Unmapped region
            end
        endcase
    end

    // Run/halt state
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            halted_q <= 1'b0;
        end else if (i_haltreq) begin
            halted_q <= 1'b1;
        end else if (i_resumereq) begin
            halted_q <= 1'b0;
        end
    end

    // Counter runs only while the hart runs, irq lines sampled each cycle
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            cycle_q       <= '0;
            irq_pending_q <= '0;
        end else begin
            if (!halted_q) begin
                cycle_q <= cycle_q + 1'b1;
            end
            irq_pending_q <= i_irq;
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            for (int i = 0; i < `WG_GPR_NUM; i++) begin
                gpr_q[i] <= '0;
            end
        end else if (gpr_we) begin
            gpr_q[gpr_idx] <= dport.req_wdata;
        end
    end

    // Response held until the interconnect takes it
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            resp_valid_q <= 1'b0;
        end else if (req_fire) begin
            resp_valid_q <= 1'b1;
        end else if (resp_valid_q && dport.resp_ready) begin
            resp_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge i_clk) begin
        if (req_fire) begin
            resp_rdata_q <= rdata_d;
            resp_error_q <= error_d;
        end
    end

    assign dport.resp_valid = resp_valid_q;
    assign dport.resp_rdata = resp_rdata_q;
    assign dport.resp_error = resp_error_q;
    assign o_halted         = halted_q;

endmodule

// ==== dport_ic.sv ====
// Debug-port interconnect, routes one request to the selected hart and returns its response
`timescale 1ns/1ps
`include "wg_consts.svh"

module dport_ic (
    input  logic                         i_clk,
    input  logic                         i_rst_n,
    // Request from the debug port
    input  logic                         i_req_valid,
    output logic                         o_req_ready,
    input  logic [`WG_HART_IDX_W-1:0]    i_req_hartsel,
    input  wg_pkg::dport_req_e           i_req_type,
    input  logic [`WG_ADDR_W-1:0]        i_req_addr,
    input  logic [`WG_DATA_W-1:0]        i_req_wdata,
    // Response to the debug port
    output logic                         o_resp_valid,
    input  logic                         i_resp_ready,
    output logic [`WG_DATA_W-1:0]        o_resp_rdata,
    output logic                         o_resp_error,
    // Run control, applies to i_req_hartsel
    input  logic                         i_haltreq,
    input  logic                         i_resumereq,
    output logic [`WG_HART_NUM-1:0]      o_hart_haltreq,
    output logic [`WG_HART_NUM-1:0]      o_hart_resumereq,
    input  logic [`WG_HART_NUM-1:0]      i_hart_halted,
    output logic [`WG_HART_NUM-1:0]      o_halted,
    output logic [`WG_HART_NUM-1:0]      o_available,
    dport_if.ic                          harts [`WG_HART_NUM]
);

    localparam logic [1:0] ST_IDLE = 2'd0;         // Ready for a new request
    localparam logic [1:0] ST_FWD  = 2'd1;         // Request presented to the hart
    localparam logic [1:0] ST_WAIT = 2'd2;         // Waiting for and holding the response

    logic [1:0]                  state_q;
    logic [`WG_HART_IDX_W-1:0]   sel_q;
    wg_pkg::dport_req_e          type_q;
    logic [`WG_ADDR_W-1:0]       addr_q;
    logic [`WG_DATA_W-1:0]       wdata_q;
    logic                        resp_valid_q;
    logic [`WG_DATA_W-1:0]       resp_rdata_q;
    logic                        resp_error_q;
    logic [`WG_HART_NUM-1:0]     halted_q;

    // Per-channel signals gathered into indexable vectors
    logic [`WG_HART_NUM-1:0]     ch_req_ready;
    logic [`WG_HART_NUM-1:0]     ch_resp_valid;
    logic [`WG_HART_NUM-1:0]     ch_resp_error;
    logic [`WG_DATA_W-1:0]       ch_resp_rdata [`WG_HART_NUM];

    logic                        req_fire;
    logic                        hart_resp_fire;

    assign o_req_ready    = (state_q == ST_IDLE);
    assign req_fire       = i_req_valid && o_req_ready;
    assign hart_resp_fire = (state_q == ST_WAIT) && !resp_valid_q && ch_resp_valid[sel_q];

    for (genvar g = 0; g < `WG_HART_NUM; g++) begin : g_chan
        // Only the latched hart sees valid, payload goes to all
        assign harts[g].req_valid  = (state_q == ST_FWD) && (sel_q == `WG_HART_IDX_W'(g));
        assign harts[g].req_type   = type_q;
        assign harts[g].req_addr   = addr_q;
        assign harts[g].req_wdata  = wdata_q;
        assign harts[g].resp_ready = (state_q == ST_WAIT) && !resp_valid_q
                                     && (sel_q == `WG_HART_IDX_W'(g));

        assign ch_req_ready[g]  = harts[g].req_ready;
        assign ch_resp_valid[g] = harts[g].resp_valid;
        assign ch_resp_error[g] = harts[g].resp_error;
        assign ch_resp_rdata[g] = harts[g].resp_rdata;

        // One-hot run control strobes
        assign o_hart_haltreq[g]   = i_haltreq && (i_req_hartsel == `WG_HART_IDX_W'(g));
        assign o_hart_resumereq[g] = i_resumereq && (i_req_hartsel == `WG_HART_IDX_W'(g));
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            state_q      <= ST_IDLE;
            sel_q        <= '0;
            resp_valid_q <= 1'b0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (req_fire) begin
                        state_q <= ST_FWD;
                        sel_q   <= i_req_hartsel;
                    end
                end
                ST_FWD: begin
                    if (ch_req_ready[sel_q]) begin  // Hart took the request
                        state_q <= ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    if (hart_resp_fire) begin
                        resp_valid_q <= 1'b1;
                    end else if (resp_valid_q && i_resp_ready) begin
                        resp_valid_q <= 1'b0;
                        state_q      <= ST_IDLE;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // Request payload and returned data
    always_ff @(posedge i_clk) begin
        if (req_fire) begin
            type_q  <= i_req_type;
            addr_q  <= i_req_addr;
            wdata_q <= i_req_wdata;
        end
        if (hart_resp_fire) begin
            resp_rdata_q <= ch_resp_rdata[sel_q];
            resp_error_q <= ch_resp_error[sel_q];
        end
    end

    // Tracks the hart flags on the same edge they change, halt has priority
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            halted_q <= '0;
        end else begin
            halted_q <= (i_hart_halted | o_hart_haltreq) & ~(o_hart_resumereq & ~o_hart_haltreq);
        end
    end

    assign o_resp_valid = resp_valid_q;
    assign o_resp_rdata = resp_rdata_q;
    assign o_resp_error = resp_error_q;
    assign o_halted     = halted_q;
    assign o_available  = {`WG_HART_NUM{1'b1}};    // Every slot holds a real hart

endmodule

// ==== dport_if.sv ====
// One debug-port request/response channel between the interconnect and a single hart
`timescale 1ns/1ps
`include "wg_consts.svh"

interface dport_if;

    // Request half, interconnect to hart
    logic                     req_valid;
    wg_pkg::dport_req_e       req_type;
    logic [`WG_ADDR_W-1:0]    req_addr;
    logic [`WG_DATA_W-1:0]    req_wdata;
    logic                     req_ready;

    // Response half, hart to interconnect
    logic                     resp_valid;
    logic [`WG_DATA_W-1:0]    resp_rdata;
    logic                     resp_error;
    logic                     resp_ready;

    modport ic (
        output req_valid, req_type, req_addr, req_wdata,
        input  req_ready,
        input  resp_valid, resp_rdata, resp_error,
        output resp_ready
    );

    modport hart (
        input  req_valid, req_type, req_addr, req_wdata,
        output req_ready,
        output resp_valid, resp_rdata, resp_error,
        input  resp_ready
    );

endinterface

// ==== wg_pkg.sv ====
// Debug-port request kinds, register regions and interrupt bit positions for the workgroup
`include "wg_consts.svh"

package wg_pkg;

    // Address split: region in the upper two bits, index below it
    localparam int unsigned IDX_W = `WG_ADDR_W - 2;

    localparam int unsigned IRQ_TOTAL = 4;          // Bits in the pending word

    typedef enum logic [1:0] {
        DPORT_READ  = 2'd0,
        DPORT_WRITE = 2'd1
    } dport_req_e;

    // Regions 2 and 3 are unmapped and answer with an error
    typedef enum logic [1:0] {
        REGION_GPR = 2'd0,
        REGION_CSR = 2'd1
    } reg_region_e;

    localparam logic [IDX_W-1:0] CSR_CYCLE       = IDX_W'(0);  // Run cycle counter
    localparam logic [IDX_W-1:0] CSR_IRQ_PENDING = IDX_W'(1);  // Latched irq lines

    typedef enum int unsigned {
        IRQ_MSIP = 0,                               // Machine software
        IRQ_MTIP = 1,                               // Machine timer
        IRQ_MEIP = 2,                               // Machine external
        IRQ_SEIP = 3                                // Supervisor external
    } irq_bit_e;

endpackage

// ==== wg_consts.svh ====
// Sizing macros for the workgroup debug subsystem, included by the package and every RTL file
`ifndef WG_CONSTS_SVH
`define WG_CONSTS_SVH

// Number of hart slots in the workgroup
`define WG_HART_NUM 4

// Hart select width, enough for WG_HART_NUM
`define WG_HART_IDX_W 2

// Debug data path width
`define WG_DATA_W 32

// Debug register address width, region in the top two bits
`define WG_ADDR_W 8

// General registers per hart
`define WG_GPR_NUM 8

`endif
